//--- hw/srv_cfg.svh
`ifndef SRV_CFG_SVH
`define SRV_CFG_SVH

// Address of the first instruction fetch
`define SRV_RESET_PC 32'h0000_0000

// Data path width, also the length of one serial pass
`define SRV_XLEN 32

// Integer register count
`define SRV_NREGS 32

`endif

//--- hw/srv_pkg.sv
`default_nettype none

`include "srv_cfg.svh"

package srv_pkg;

   typedef enum logic [3:0] {
      op_addi,
      op_add,
      op_sub,
      op_and,
      op_or,
      op_xor,
      op_lui,
      op_lw,
      op_sw,
      op_beq,
      op_bne,
      op_jal,
      op_nop
   } srv_op_e;

   typedef enum logic [2:0] {
      st_fetch,
      st_decode,
      st_exec,
      st_mem,
      st_wback
   } srv_state_e;

   typedef struct packed {
      logic [`SRV_XLEN-1:0] adr;
      logic                 cyc;
   } srv_ibus_req_t;

   typedef struct packed {
      logic [`SRV_XLEN-1:0] adr;
      logic [`SRV_XLEN-1:0] dat;
      logic                 we;
      logic                 cyc;
   } srv_dbus_req_t;

   typedef struct packed {
      logic [`SRV_XLEN-1:0] rdt;
      logic                 ack;
   } srv_bus_rsp_t;

   // Boolean select 00 adder, 01 xor, 10 or and 11 and
   typedef struct packed {
      srv_op_e    op;
      logic       rd_we;
      logic       use_imm;
      logic       alu_sub;
      logic [1:0] alu_bool;
      logic       is_branch;
   } srv_ctrl_t;

endpackage

`default_nettype wire

//--- hw/srv_state.sv
`timescale 1ns/1ps
`default_nettype none

`include "srv_cfg.svh"

module srv_state (
   input  wire                clk,
   input  wire                i_rst_n,
   input  wire srv_pkg::srv_ctrl_t i_ctrl,
   input  wire                i_ibus_ack,
   input  wire                i_dbus_ack,
   output logic               o_ibus_cyc,
   output logic               o_dbus_cyc,
   output logic               o_init,
   output logic               o_cnt_en,
   output logic               o_cnt_done,
   output logic [4:0]         o_cnt,
   output logic               o_rd_en,
   output logic               o_pc_en
);
   import srv_pkg::*;

   srv_state_e state_q;
   srv_state_e state_d;
   logic [4:0] cnt_q;
   logic       mem_op;
   logic       is_load;

   assign is_load = (i_ctrl.op == op_lw);
   assign mem_op  = is_load || (i_ctrl.op == op_sw);

   assign o_cnt      = cnt_q;
   assign o_cnt_en   = (state_q == st_exec) || (state_q == st_wback);
   assign o_cnt_done = o_cnt_en && (cnt_q == 5'(`SRV_XLEN - 1));
   assign o_init     = (state_q == st_exec) && (cnt_q == 5'd0);
   assign o_ibus_cyc = (state_q == st_fetch);
   assign o_dbus_cyc = (state_q == st_mem);

   // Loads write rd from the wback pass only
   assign o_rd_en = ((state_q == st_exec) && i_ctrl.rd_we && !is_load) ||
                    (state_q == st_wback);

   // Wback never touches the PC, so memory ops move it at the bus ack
   assign o_pc_en = ((state_q == st_exec) && o_cnt_done && !mem_op) ||
                    ((state_q == st_mem) && i_dbus_ack);

   always_comb begin
      state_d = state_q;
      case (state_q)
         st_fetch:  if (i_ibus_ack) state_d = st_decode;
         st_decode: state_d = st_exec;
         st_exec: begin
            if (o_cnt_done) begin
               state_d = mem_op ? st_mem : st_fetch;
            end
         end
         st_mem: begin
            if (i_dbus_ack) begin
               state_d = is_load ? st_wback : st_fetch;
            end
         end
         st_wback:  if (o_cnt_done) state_d = st_fetch;
         default:   state_d = st_fetch;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= st_fetch;
         cnt_q   <= 5'd0;
      end else begin
         state_q <= state_d;
         if (o_cnt_en) begin
            cnt_q <= cnt_q + 5'd1;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/srv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "srv_cfg.svh"

module srv_decode (
   input  wire                clk,
   input  wire                i_rst_n,
   input  wire  [31:0]        i_rdt,
   input  wire                i_wen,
   input  wire                i_cnt_en,
   output srv_pkg::srv_ctrl_t o_ctrl,
   output logic               o_imm,
   output logic [4:0]         o_rd_addr,
   output logic [4:0]         o_rs1_addr,
   output logic [4:0]         o_rs2_addr
);
   import srv_pkg::*;

   logic [`SRV_XLEN-1:0] insn_q;
   logic [`SRV_XLEN-1:0] imm_q;
   srv_op_e              op;

   function automatic srv_op_e decode_op(input logic [31:0] w);
      srv_op_e res;
      res = op_nop;
      case (w[6:0])
         7'b0010011: if (w[14:12] == 3'b000) res = op_addi;
         7'b0110011: begin
            if (w[31:25] == 7'b0000000) begin
               case (w[14:12])
                  3'b000:  res = op_add;
                  3'b100:  res = op_xor;
                  3'b110:  res = op_or;
                  3'b111:  res = op_and;
                  default: res = op_nop;
               endcase
            end else if (w[31:25] == 7'b0100000 && w[14:12] == 3'b000) begin
               res = op_sub;
            end
         end
         7'b0110111: res = op_lui;
         7'b0000011: if (w[14:12] == 3'b010) res = op_lw;
         7'b0100011: if (w[14:12] == 3'b010) res = op_sw;
         7'b1100011: begin
            if (w[14:12] == 3'b000) begin
               res = op_beq;
            end else if (w[14:12] == 3'b001) begin
               res = op_bne;
            end
         end
         7'b1101111: res = op_jal;
         default:    res = op_nop;
      endcase
      return res;
   endfunction

   // Immediate format follows the operation
   function automatic logic [31:0] decode_imm(input logic [31:0] w, input srv_op_e op_in);
      logic [31:0] res;
      case (op_in)
         op_sw:          res = {{20{w[31]}}, w[31:25], w[11:7]};
         op_beq, op_bne: res = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
         op_lui:         res = {w[31:12], 12'd0};
         op_jal:         res = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
         default:        res = {{20{w[31]}}, w[31:20]};
      endcase
      return res;
   endfunction

   assign op = decode_op(insn_q);

   always_comb begin
      o_ctrl.op        = op;
      o_ctrl.rd_we     = op inside {op_addi, op_add, op_sub, op_and, op_or, op_xor,
                                    op_lui, op_lw, op_jal};
      o_ctrl.use_imm   = op inside {op_addi, op_lui, op_lw, op_sw};
      o_ctrl.alu_sub   = op inside {op_sub, op_beq, op_bne};
      o_ctrl.is_branch = op inside {op_beq, op_bne};
      case (op)
         op_xor:  o_ctrl.alu_bool = 2'b01;
         op_or:   o_ctrl.alu_bool = 2'b10;
         op_and:  o_ctrl.alu_bool = 2'b11;
         default: o_ctrl.alu_bool = 2'b00;
      endcase
   end

   assign o_rd_addr  = insn_q[11:7];
   assign o_rs1_addr = insn_q[19:15];
   assign o_rs2_addr = insn_q[24:20];
   assign o_imm      = imm_q[0];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         insn_q <= '0;
      end else if (i_wen) begin
         insn_q <= i_rdt;
      end
   end

   // Sign bit is kept while shifting
   always_ff @(posedge clk) begin
      if (i_wen) begin
         imm_q <= decode_imm(i_rdt, decode_op(i_rdt));
      end else if (i_cnt_en) begin
         imm_q <= {imm_q[`SRV_XLEN-1], imm_q[`SRV_XLEN-1:1]};
      end
   end

endmodule

`default_nettype wire

//--- hw/srv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module srv_alu (
   input  wire                clk,
   input  wire                i_rst_n,
   input  wire srv_pkg::srv_ctrl_t i_ctrl,
   input  wire                i_init,
   input  wire                i_cnt_en,
   input  wire                i_rs1,
   input  wire                i_rs2,
   input  wire                i_imm,
   output logic               o_rd,
   output logic               o_eq
);
   import srv_pkg::*;

   logic op_a;
   logic op_b;
   logic b_add;
   logic c_in;
   logic c_q;
   logic sum;
   logic diff_in;
   logic diff_q;

   // LUI is imm + 0
   assign op_a  = (i_ctrl.op == op_lui) ? 1'b0 : i_rs1;
   assign op_b  = i_ctrl.use_imm ? i_imm : i_rs2;
   assign b_add = op_b ^ i_ctrl.alu_sub;
   assign c_in  = i_init ? i_ctrl.alu_sub : c_q;
   assign sum   = op_a ^ b_add ^ c_in;

   assign diff_in = ~i_init & diff_q;
   assign o_eq    = ~(diff_in | (i_rs1 ^ i_rs2));

   always_comb begin
      case (i_ctrl.alu_bool)
         2'b01:   o_rd = op_a ^ op_b;
         2'b10:   o_rd = op_a | op_b;
         2'b11:   o_rd = op_a & op_b;
         default: o_rd = sum;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         c_q    <= 1'b0;
         diff_q <= 1'b0;
      end else if (i_cnt_en) begin
         c_q    <= (op_a & b_add) | (c_in & (op_a ^ b_add));
         diff_q <= diff_in | (i_rs1 ^ i_rs2);
      end
   end

endmodule

`default_nettype wire

//--- hw/srv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "srv_cfg.svh"

module srv_ctrl (
   input  wire                clk,
   input  wire                i_rst_n,
   input  wire srv_pkg::srv_ctrl_t i_ctrl,
   input  wire                i_cnt_en,
   input  wire                i_init,
   input  wire                i_pc_en,
   input  wire                i_eq,
   input  wire                i_imm,
   output logic               o_ret,
   output logic [31:0]        o_ibus_adr
);
   import srv_pkg::*;

   logic [`SRV_XLEN-1:0] pc_q;
   logic [`SRV_XLEN-1:0] nxt_q;
   logic [`SRV_XLEN-1:0] tgt_q;
   logic [`SRV_XLEN-1:0] nxt_full;
   logic [`SRV_XLEN-1:0] tgt_full;
   logic [1:0]           four_q;
   logic                 c4_q;
   logic                 ct_q;
   logic                 add4;
   logic                 c4_in;
   logic                 ct_in;
   logic                 sum4;
   logic                 sumt;
   logic                 jump;

   // Constant 4 appears on bit 2 only
   assign add4  = ~i_init & four_q[0];
   assign c4_in = ~i_init & c4_q;
   assign ct_in = ~i_init & ct_q;
   assign sum4  = pc_q[0] ^ add4 ^ c4_in;
   assign sumt  = pc_q[0] ^ i_imm ^ ct_in;

   // On the last exec bit the sums still hold their top bit
   assign nxt_full = i_cnt_en ? {sum4, nxt_q[`SRV_XLEN-1:1]} : nxt_q;
   assign tgt_full = i_cnt_en ? {sumt, tgt_q[`SRV_XLEN-1:1]} : tgt_q;

   assign jump = (i_ctrl.op == op_jal) |
                 (i_ctrl.is_branch & (i_eq ^ (i_ctrl.op == op_bne)));

   assign o_ret      = sum4;
   assign o_ibus_adr = pc_q;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc_q   <= `SRV_RESET_PC;
         four_q <= 2'b00;
         c4_q   <= 1'b0;
         ct_q   <= 1'b0;
      end else begin
         if (i_pc_en) begin
            pc_q <= jump ? tgt_full : nxt_full;
         end else if (i_cnt_en) begin
            pc_q <= {pc_q[0], pc_q[`SRV_XLEN-1:1]};
         end
         if (i_init) begin
            four_q <= 2'b10;
         end else if (i_cnt_en) begin
            four_q <= {1'b0, four_q[1]};
         end
         if (i_cnt_en) begin
            c4_q <= (pc_q[0] & add4) | (c4_in & (pc_q[0] ^ add4));
            ct_q <= (pc_q[0] & i_imm) | (ct_in & (pc_q[0] ^ i_imm));
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         nxt_q <= {sum4, nxt_q[`SRV_XLEN-1:1]};
         tgt_q <= {sumt, tgt_q[`SRV_XLEN-1:1]};
      end
   end

endmodule

`default_nettype wire

//--- hw/srv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "srv_cfg.svh"

module srv_lsu (
   input  wire                  clk,
   input  wire                  i_rst_n,
   input  wire srv_pkg::srv_ctrl_t   i_ctrl,
   input  wire                  i_cnt_en,
   input  wire                  i_init,
   input  wire                  i_rs1,
   input  wire                  i_rs2,
   input  wire                  i_imm,
   input  wire srv_pkg::srv_bus_rsp_t i_rsp,
   output logic [31:0]          o_adr,
   output logic [31:0]          o_dat,
   output logic                 o_we,
   output logic                 o_rd
);
   import srv_pkg::*;

   logic [`SRV_XLEN-1:0] adr_q;
   logic [`SRV_XLEN-1:0] dat_q;
   logic                 c_q;
   logic                 c_in;
   logic                 sum;

   assign c_in = ~i_init & c_q;
   assign sum  = i_rs1 ^ i_imm ^ c_in;

   // Word accesses only
   assign o_adr = adr_q & ~32'd3;
   assign o_dat = dat_q;
   assign o_we  = (i_ctrl.op == op_sw);
   assign o_rd  = dat_q[0];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         c_q <= 1'b0;
      end else if (i_cnt_en) begin
         c_q <= (i_rs1 & i_imm) | (c_in & (i_rs1 ^ i_imm));
      end
   end

   // Same register holds store data in exec and load data in wback
   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         adr_q <= {sum, adr_q[`SRV_XLEN-1:1]};
      end
      if (i_rsp.ack && (i_ctrl.op == op_lw)) begin
         dat_q <= i_rsp.rdt;
      end else if (i_cnt_en) begin
         dat_q <= {i_rs2, dat_q[`SRV_XLEN-1:1]};
      end
   end

endmodule

`default_nettype wire

//--- hw/srv_rf.sv
`timescale 1ns/1ps
`default_nettype none

`include "srv_cfg.svh"

module srv_rf (
   input  wire                clk,
   input  wire                i_rst_n,
   input  wire  [4:0]         i_cnt,
   input  wire  [4:0]         i_rs1_addr,
   input  wire  [4:0]         i_rs2_addr,
   input  wire  [4:0]         i_rd_addr,
   input  wire                i_rd_en,
   input  wire srv_pkg::srv_op_e i_op,
   input  wire                i_alu_rd,
   input  wire                i_ret,
   input  wire                i_mem_rd,
   output logic               o_rs1,
   output logic               o_rs2
);
   import srv_pkg::*;

   logic [`SRV_XLEN-1:0] regs [`SRV_NREGS];
   logic                 wr_bit;

   always_comb begin
      case (i_op)
         op_jal:  wr_bit = i_ret;
         op_lw:   wr_bit = i_mem_rd;
         default: wr_bit = i_alu_rd;
      endcase
   end

   // Old bit is read while the same bit is written
   assign o_rs1 = regs[i_rs1_addr][i_cnt];
   assign o_rs2 = regs[i_rs2_addr][i_cnt];

   // x0 is cleared here and never written again
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < `SRV_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_en && (i_rd_addr != 5'd0)) begin
         regs[i_rd_addr][i_cnt] <= wr_bit;
      end
   end

endmodule

`default_nettype wire

//--- hw/srv_top.sv
`timescale 1ns/1ps
`default_nettype none

module srv_top (
   input  wire                     clk,
   input  wire                     i_rst_n,
   output srv_pkg::srv_ibus_req_t  o_ibus,
   input  wire srv_pkg::srv_bus_rsp_t i_ibus,
   output srv_pkg::srv_dbus_req_t  o_dbus,
   input  wire srv_pkg::srv_bus_rsp_t i_dbus
);
   import srv_pkg::*;

   srv_ctrl_t   ctrl;
   logic [4:0]  cnt;
   logic [4:0]  rd_addr;
   logic [4:0]  rs1_addr;
   logic [4:0]  rs2_addr;
   logic [31:0] ibus_adr;
   logic [31:0] dbus_adr;
   logic [31:0] dbus_dat;
   logic        ibus_cyc;
   logic        dbus_cyc;
   logic        dbus_we;
   logic        init;
   logic        cnt_en;
   logic        cnt_done;
   logic        rd_en;
   logic        pc_en;
   logic        imm;
   logic        rs1;
   logic        rs2;
   logic        alu_rd;
   logic        alu_eq;
   logic        cmp_eq;
   logic        ret;
   logic        mem_rd;

   assign o_ibus = '{adr: ibus_adr, cyc: ibus_cyc};
   assign o_dbus = '{adr: dbus_adr, dat: dbus_dat, we: dbus_we, cyc: dbus_cyc};

   // Compare is final on the last bit only
   assign cmp_eq = alu_eq & cnt_done;

   srv_state srv_state_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ctrl     (ctrl),
      .i_ibus_ack (i_ibus.ack),
      .i_dbus_ack (i_dbus.ack),
      .o_ibus_cyc (ibus_cyc),
      .o_dbus_cyc (dbus_cyc),
      .o_init     (init),
      .o_cnt_en   (cnt_en),
      .o_cnt_done (cnt_done),
      .o_cnt      (cnt),
      .o_rd_en    (rd_en),
      .o_pc_en    (pc_en)
   );

   srv_decode srv_decode_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_rdt      (i_ibus.rdt),
      .i_wen      (ibus_cyc & i_ibus.ack),
      .i_cnt_en   (cnt_en),
      .o_ctrl     (ctrl),
      .o_imm      (imm),
      .o_rd_addr  (rd_addr),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr)
   );

   srv_alu srv_alu_i (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_ctrl   (ctrl),
      .i_init   (init),
      .i_cnt_en (cnt_en),
      .i_rs1    (rs1),
      .i_rs2    (rs2),
      .i_imm    (imm),
      .o_rd     (alu_rd),
      .o_eq     (alu_eq)
   );

   srv_ctrl srv_ctrl_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ctrl     (ctrl),
      .i_cnt_en   (cnt_en),
      .i_init     (init),
      .i_pc_en    (pc_en),
      .i_eq       (cmp_eq),
      .i_imm      (imm),
      .o_ret      (ret),
      .o_ibus_adr (ibus_adr)
   );

   srv_lsu srv_lsu_i (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_ctrl   (ctrl),
      .i_cnt_en (cnt_en),
      .i_init   (init),
      .i_rs1    (rs1),
      .i_rs2    (rs2),
      .i_imm    (imm),
      .i_rsp    (i_dbus),
      .o_adr    (dbus_adr),
      .o_dat    (dbus_dat),
      .o_we     (dbus_we),
      .o_rd     (mem_rd)
   );

   srv_rf srv_rf_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt      (cnt),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_en    (rd_en),
      .i_op       (ctrl.op),
      .i_alu_rd   (alu_rd),
      .i_ret      (ret),
      .i_mem_rd   (mem_rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

endmodule

`default_nettype wire

//--- dv/srv_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "srv_cfg.svh"

module srv_tb;
   import srv_pkg::*;

   localparam int TOTAL_INSNS = 260;
   localparam int MARGIN      = 500;
   localparam int MAX_DELAY   = 3;
   localparam logic [31:0] HALT = 32'h0000_006f;

   typedef struct packed {
      logic [31:0] pc;
      logic        st;
      logic [31:0] adr;
      logic [31:0] dat;
   } step_t;

   logic          clk;
   logic          rst_n;
   srv_ibus_req_t ibus_req;
   srv_bus_rsp_t  ibus_rsp;
   srv_dbus_req_t dbus_req;
   srv_bus_rsp_t  dbus_rsp;

   logic [31:0] mem [256];
   logic [31:0] ref_mem [256];
   logic [31:0] ref_regs [32];
   logic [31:0] ref_pc;
   logic [31:0] rng;
   logic [31:0] exp_adr;
   logic [31:0] exp_dat;
   logic        store_pending;
   logic        halt_seen;
   int          errors;
   int          fetch_count;
   int          prog_ptr;
   int          iwait;
   int          dwait;
   int          idly;
   int          ddly;
   int          tests_run;
   int          tests_failed;

   srv_top srv_top_i (
      .clk     (clk),
      .i_rst_n (rst_n),
      .o_ibus  (ibus_req),
      .i_ibus  (ibus_rsp),
      .o_dbus  (dbus_req),
      .i_dbus  (dbus_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      repeat ((TOTAL_INSNS * 45 + MARGIN) * (MAX_DELAY + 1)) @(posedge clk);
      $display("watchdog expired before the tests finished");
      $display("=== FAIL ===");
      $finish;
   end

   function automatic logic [31:0] rand32();
      rng = rng * 32'd1664525 + 32'd1013904223;
      return rng;
   endfunction

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = rand32();
      return int'({8'd0, r[31:8]}) % n;
   endfunction

   function automatic logic [31:0] itype(input logic [31:0] imm, input logic [31:0] rs1,
                                         input logic [31:0] f3, input logic [31:0] rd,
                                         input logic [31:0] opc);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
   endfunction

   function automatic logic [31:0] rtype(input logic [31:0] f7, input logic [31:0] rs2,
                                         input logic [31:0] rs1, input logic [31:0] f3,
                                         input logic [31:0] rd);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
   endfunction

   function automatic logic [31:0] stype(input logic [31:0] imm, input logic [31:0] rs2,
                                         input logic [31:0] rs1);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
   endfunction

   function automatic logic [31:0] btype(input logic [31:0] imm, input logic [31:0] rs2,
                                         input logic [31:0] rs1, input logic [31:0] f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
   endfunction

   function automatic logic [31:0] utype(input logic [31:0] imm, input logic [31:0] rd);
      return {imm[19:0], rd[4:0], 7'h37};
   endfunction

   function automatic logic [31:0] jtype(input logic [31:0] imm, input logic [31:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
   endfunction

   // One instruction of the subset on the model state
   function automatic step_t ref_step(input logic [31:0] pc);
      step_t       r;
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] i_imm;
      logic [31:0] s_imm;
      logic [31:0] b_imm;
      logic [31:0] j_imm;
      logic [31:0] res;
      logic [31:0] ea;
      logic        wr;
      w     = ref_mem[pc[9:2]];
      a     = ref_regs[w[19:15]];
      b     = ref_regs[w[24:20]];
      i_imm = {{20{w[31]}}, w[31:20]};
      s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
      b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      r     = '0;
      r.pc  = pc + 32'd4;
      wr    = 1'b0;
      res   = '0;
      case (w[6:0])
         7'h13: if (w[14:12] == 3'd0) begin
            res = a + i_imm;
            wr  = 1'b1;
         end
         7'h33: begin
            wr = 1'b1;
            case ({w[31:25], w[14:12]})
               10'h000: res = a + b;
               10'h100: res = a - b;
               10'h004: res = a ^ b;
               10'h006: res = a | b;
               10'h007: res = a & b;
               default: wr = 1'b0;
            endcase
         end
         7'h37: begin
            res = {w[31:12], 12'd0};
            wr  = 1'b1;
         end
         7'h03: if (w[14:12] == 3'd2) begin
            ea  = a + i_imm;
            res = ref_mem[ea[9:2]];
            wr  = 1'b1;
         end
         7'h23: if (w[14:12] == 3'd2) begin
            r.st  = 1'b1;
            r.adr = (a + s_imm) & ~32'd3;
            r.dat = b;
            ref_mem[r.adr[9:2]] = b;
         end
         7'h63: begin
            if ((w[14:12] == 3'd0 && a == b) || (w[14:12] == 3'd1 && a != b)) begin
               r.pc = pc + b_imm;
            end
         end
         7'h6f: begin
            res  = pc + 32'd4;
            wr   = 1'b1;
            r.pc = pc + j_imm;
         end
         default: wr = 1'b0;
      endcase
      if (wr && w[11:7] != 5'd0) begin
         ref_regs[w[11:7]] = res;
      end
      return r;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic handle_fetch(input logic [31:0] adr);
      step_t s;
      check("o_ibus.adr", adr, ref_pc);
      if (store_pending) begin
         $display("store to %h was expected but never seen", exp_adr);
         errors++;
         store_pending = 1'b0;
      end
      fetch_count++;
      if (ref_mem[ref_pc[9:2]] == HALT) begin
         halt_seen = 1'b1;
      end
      s = ref_step(ref_pc);
      ref_pc = s.pc;
      if (s.st) begin
         store_pending = 1'b1;
         exp_adr       = s.adr;
         exp_dat       = s.dat;
      end
   endtask

   task automatic handle_store(input logic [31:0] adr, input logic [31:0] dat);
      if (!store_pending) begin
         $display("store to %h seen where the program has none", adr);
         errors++;
      end else begin
         check("o_dbus.adr", adr, exp_adr);
         check("o_dbus.dat", dat, exp_dat);
         store_pending = 1'b0;
      end
   endtask

   // Memory model for both buses with randomly delayed acks
   always @(negedge clk) begin
      if (!rst_n || halt_seen) begin
         ibus_rsp.ack = 1'b0;
         dbus_rsp.ack = 1'b0;
         iwait        = 0;
         dwait        = 0;
      end else begin
         if (ibus_rsp.ack) begin
            ibus_rsp.ack = 1'b0;
         end else if (ibus_req.cyc) begin
            if (iwait >= idly) begin
               ibus_rsp.ack = 1'b1;
               ibus_rsp.rdt = mem[ibus_req.adr[9:2]];
               iwait        = 0;
               idly         = rand_below(MAX_DELAY + 1);
               handle_fetch(ibus_req.adr);
            end else begin
               iwait++;
            end
         end
         if (dbus_rsp.ack) begin
            dbus_rsp.ack = 1'b0;
         end else if (dbus_req.cyc) begin
            if (dwait >= ddly) begin
               if (dbus_req.we) begin
                  mem[dbus_req.adr[9:2]] = dbus_req.dat;
                  handle_store(dbus_req.adr, dbus_req.dat);
               end
               dbus_rsp.ack = 1'b1;
               dbus_rsp.rdt = mem[dbus_req.adr[9:2]];
               dwait        = 0;
               ddly         = rand_below(MAX_DELAY + 1);
            end else begin
               dwait++;
            end
         end
      end
   end

   task automatic clear_memory();
      for (int i = 0; i < 256; i++) begin
         mem[i] = (32'(i) * 32'h0101_0101) ^ 32'hc3a5_0f00 ^ (32'(i) << 20);
      end
      prog_ptr = 0;
   endtask

   task automatic emit(input logic [31:0] w);
      mem[prog_ptr] = w;
      prog_ptr++;
   endtask

   task automatic start_program();
      @(negedge clk);
      rst_n <= 1'b0;
      for (int i = 0; i < 256; i++) begin
         ref_mem[i] = mem[i];
      end
      for (int i = 0; i < 32; i++) begin
         ref_regs[i] = '0;
      end
      ref_pc        = `SRV_RESET_PC;
      fetch_count   = 0;
      store_pending = 1'b0;
      repeat (8) @(negedge clk);
      halt_seen = 1'b0;
      rst_n <= 1'b1;
   endtask

   task automatic wait_halt();
      while (!halt_seen) @(negedge clk);
   endtask

   task automatic report(input int num, input string name, input int err0);
      tests_run++;
      if (errors != err0) begin
         tests_failed++;
      end
      $display("test %0d %s: %s (%0d errors)", num, name,
               (errors == err0) ? "ok" : "failed", errors - err0);
   endtask

   task automatic gen_random();
      int          k;
      int          pc;
      int          off;
      int          rd;
      int          r1;
      int          r2;
      logic [31:0] w;
      for (int n = 0; n < 200; n++) begin
         k   = rand_below(13);
         rd  = rand_below(8);
         r1  = rand_below(8);
         r2  = rand_below(8);
         pc  = n * 4;
         off = 4 * (1 + rand_below(4));
         // Forward only and never past the halt word at 0x320
         if (pc + off > 800) begin
            off = 800 - pc;
         end
         case (k)
            0:  w = itype(rand_below(4096), r1, 0, rd, 32'h13);
            1:  w = rtype(0, r2, r1, 0, rd);
            2:  w = rtype(32'h20, r2, r1, 0, rd);
            3:  w = rtype(0, r2, r1, 7, rd);
            4:  w = rtype(0, r2, r1, 6, rd);
            5:  w = rtype(0, r2, r1, 4, rd);
            6:  w = utype(rand32(), rd);
            7:  w = itype(32'h380 + 4 * rand_below(32), 0, 2, rd, 32'h03);
            8:  w = stype(32'h380 + 4 * rand_below(32), r2, 0);
            9:  w = btype(off, r2, r1, 0);
            10: w = btype(off, r2, r1, 1);
            11: w = jtype(off, rd);
            default: begin
               if (rand_below(2) == 0) begin
                  w = rand32();
                  w[6:0] = 7'h0b;
               end else begin
                  w = itype(rand_below(32), r1, 1, rd, 32'h13);
               end
            end
         endcase
         emit(w);
      end
      emit(HALT);
   endtask

   initial begin
      int err0;
      rst_n         = 1'b0;
      ibus_rsp      = '0;
      dbus_rsp      = '0;
      rng           = 32'h28ea_f078;
      halt_seen     = 1'b1;
      store_pending = 1'b0;
      errors        = 0;
      tests_run     = 0;
      tests_failed  = 0;
      idly          = 0;
      ddly          = 0;

      // Reset state and first fetch
      err0 = errors;
      clear_memory();
      emit(itype(32'h5a, 0, 0, 1, 32'h13));
      emit(stype(32'h3c0, 1, 0));
      emit(HALT);
      start_program();
      @(negedge clk);
      check("o_ibus.cyc", {31'd0, ibus_req.cyc}, 32'd1);
      check("o_ibus.adr", ibus_req.adr, `SRV_RESET_PC);
      while (fetch_count < 2 && !halt_seen) begin
         check("o_dbus.cyc", {31'd0, dbus_req.cyc}, 32'd0);
         check("o_dbus.we", {31'd0, dbus_req.we}, 32'd0);
         @(negedge clk);
      end
      wait_halt();
      report(1, "reset and first fetch", err0);

      // ALU operations with a store after each
      err0 = errors;
      clear_memory();
      emit(itype(32'h123, 0, 0, 1, 32'h13));
      emit(stype(32'h380, 1, 0));
      emit(utype(32'habcde, 2));
      emit(stype(32'h384, 2, 0));
      emit(rtype(0, 2, 1, 0, 3));
      emit(stype(32'h388, 3, 0));
      emit(rtype(32'h20, 2, 1, 0, 4));
      emit(stype(32'h38c, 4, 0));
      emit(rtype(0, 2, 3, 7, 5));
      emit(stype(32'h390, 5, 0));
      emit(rtype(0, 2, 1, 6, 6));
      emit(stype(32'h394, 6, 0));
      emit(rtype(0, 4, 3, 4, 7));
      emit(stype(32'h398, 7, 0));
      emit(itype(32'hffff_f9c4, 7, 0, 7, 32'h13));
      emit(stype(32'h39c, 7, 0));
      emit(HALT);
      start_program();
      wait_halt();
      report(2, "alu operations", err0);

      // Store and load back with x0 held at zero
      err0 = errors;
      clear_memory();
      emit(itype(32'h5a5, 0, 0, 1, 32'h13));
      emit(utype(32'h12345, 2));
      emit(rtype(0, 1, 2, 0, 2));
      emit(stype(32'h390, 2, 0));
      emit(itype(32'h390, 0, 2, 3, 32'h03));
      emit(stype(32'h394, 3, 0));
      emit(itype(32'h21, 0, 0, 0, 32'h13));
      emit(rtype(0, 2, 2, 0, 0));
      emit(stype(32'h398, 0, 0));
      emit(itype(32'h3a0, 0, 2, 4, 32'h03));
      emit(stype(32'h3a4, 4, 0));
      emit(HALT);
      start_program();
      wait_halt();
      report(3, "load store and x0", err0);

      // Branches and JAL
      err0 = errors;
      clear_memory();
      emit(itype(7, 0, 0, 1, 32'h13));
      emit(itype(7, 0, 0, 2, 32'h13));
      emit(btype(8, 2, 1, 0));
      emit(itype(1, 0, 0, 3, 32'h13));
      emit(btype(8, 2, 1, 1));
      emit(btype(8, 0, 1, 0));
      emit(btype(8, 0, 1, 1));
      emit(itype(9, 0, 0, 4, 32'h13));
      emit(jtype(8, 5));
      emit(itype(3, 0, 0, 6, 32'h13));
      emit(stype(32'h3b0, 5, 0));
      emit(stype(32'h3b4, 3, 0));
      emit(HALT);
      start_program();
      wait_halt();
      report(4, "branches and jal", err0);

      // Random program
      err0 = errors;
      clear_memory();
      gen_random();
      start_program();
      wait_halt();
      report(5, "random program", err0);

      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
+incdir+hw
hw/srv_pkg.sv
hw/srv_state.sv
hw/srv_decode.sv
hw/srv_alu.sv
hw/srv_ctrl.sv
hw/srv_lsu.sv
hw/srv_rf.sv
hw/srv_top.sv
dv/srv_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= srv_tb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED_ARGS ?=
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard hw/*.sv hw/*.svh dv/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) > $(LOG) 2>&1 ; cat $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
